/* tb.f */
+incdir+test
hw/colmix_pkg.sv
hw/pal_ram.sv
hw/prio_prom.sv
hw/colmix_regs.sv
hw/colmix.sv
hw/colmix_top.sv
test/tb_colmix.sv

/* Makefile */
# Verilator build and run of the color mixer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_colmix -Mdir obj_dir
	-./obj_dir/Vtb_colmix > sim.log 2>&1
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* test/tb_colmix_table.svh */
// --------------------
// pixel rows for tb_colmix, included inside the module
// prom fill assumes the address {scr7, obj7, obj_blank, char_blank, scr_lo}
// --------------------

`ifndef TB_COLMIX_TABLE_SVH
`define TB_COLMIX_TABLE_SVH

typedef struct packed {
    pixel_in_t   px;
    layer_mask_t mask;
    logic        rw;      // rewrite the picked palette entry first
} row_t;

// priority codes, every address bit matters
function automatic logic [1:0] prom_fill(input logic [7:0] a);
    if (a[7] && a[3:0] != 4'h0 && !a[6])
        return 2'd3;                   // scroll over everything
    else if (!a[4])
        return {1'b0, a[0] ^ a[6]};    // char, code 0 or 1
    else if (!a[5])
        return 2'd2;
    else if (a[3:0] != 4'h0)
        return 2'd3;
    else
        return {1'b0, a[6]};           // backdrop from the char bank
endfunction

localparam int n_rows = 23;

// columns: {char, obj, scr, hbl, vbl}, mask {char_off, obj_off}, rewrite
localparam row_t rows [n_rows] = '{
    '{'{7'h15, 8'h00, 8'h02, 1'b0, 1'b0}, 2'b00, 1'b0},   // char
    '{'{7'h10, 8'h23, 8'h04, 1'b0, 1'b0}, 2'b00, 1'b0},   // obj
    '{'{7'h00, 8'h00, 8'h37, 1'b0, 1'b0}, 2'b00, 1'b0},   // scroll
    '{'{7'h2a, 8'h00, 8'h85, 1'b0, 1'b0}, 2'b00, 1'b0},   // scroll over char
    '{'{7'h2a, 8'hc1, 8'h85, 1'b0, 1'b0}, 2'b00, 1'b0},
    '{'{7'h00, 8'h00, 8'h00, 1'b0, 1'b0}, 2'b00, 1'b0},   // backdrop
    '{'{7'h00, 8'h9e, 8'h83, 1'b0, 1'b0}, 2'b00, 1'b0},
    '{'{7'h31, 8'h00, 8'h10, 1'b0, 1'b0}, 2'b00, 1'b0},
    '{'{7'h15, 8'h23, 8'h04, 1'b1, 1'b0}, 2'b00, 1'b0},   // hblank
    '{'{7'h15, 8'h23, 8'h04, 1'b0, 1'b1}, 2'b00, 1'b0},   // vblank
    '{'{7'h15, 8'h23, 8'h04, 1'b1, 1'b1}, 2'b00, 1'b0},
    '{'{7'h15, 8'h23, 8'h04, 1'b0, 1'b0}, 2'b00, 1'b0},   // visible again
    '{'{7'h15, 8'h23, 8'h04, 1'b0, 1'b0}, 2'b10, 1'b0},   // char hidden
    '{'{7'h2a, 8'h00, 8'h37, 1'b0, 1'b0}, 2'b10, 1'b0},
    '{'{7'h7f, 8'h4c, 8'h11, 1'b0, 1'b0}, 2'b10, 1'b0},
    '{'{7'h10, 8'h23, 8'h04, 1'b0, 1'b0}, 2'b01, 1'b0},   // obj hidden
    '{'{7'h3b, 8'h45, 8'h01, 1'b0, 1'b0}, 2'b01, 1'b0},
    '{'{7'h00, 8'h5a, 8'h00, 1'b0, 1'b0}, 2'b01, 1'b0},
    '{'{7'h15, 8'h23, 8'h06, 1'b0, 1'b0}, 2'b11, 1'b0},   // both hidden
    '{'{7'h15, 8'h00, 8'h02, 1'b0, 1'b0}, 2'b00, 1'b1},   // char 15 rewritten
    '{'{7'h15, 8'h23, 8'h04, 1'b0, 1'b0}, 2'b00, 1'b0},
    '{'{7'h10, 8'h23, 8'h04, 1'b0, 1'b0}, 2'b00, 1'b0},
    '{'{7'h15, 8'h00, 8'h0a, 1'b0, 1'b0}, 2'b00, 1'b0}
};

`endif

/* test/tb_colmix.sv */
// --------------------
// pxl_cen runs at half the clock rate once reset is done
// palette and prom are filled over Wishbone before any pixel
// stops at the first mismatch
// --------------------

`timescale 1ns/1ps

module tb_colmix;
    import colmix_pkg::*;

    `include "tb_colmix_table.svh"

    typedef struct packed {
        rgb_t       c;
        logic [1:0] fl;      // {lhbl, lvbl}
    } exp_t;

    // blanked, all layers transparent
    localparam pixel_in_t idle_px = '{char_pxl: '0, obj_pxl: '0, scr_pxl: '0,
                                      hbl: 1'b1, vbl: 1'b1};

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        cen_on;       // enable runs only after reset
    wb_req_t     wb;
    wb_rsp_t     wb_rsp;
    pixel_in_t   pxl;
    rgb_t        rgb;
    logic        lhbl_dly;
    logic        lvbl_dly;

    logic [31:0] lfsr;
    logic [7:0]  gr_sh [512];  // shadow of the red/green bank
    logic [3:0]  b_sh [512];
    logic [1:0]  prom_sh [256];
    layer_mask_t cur_mask;
    exp_t        exp_q [$];    // pixels still in the pipeline
    int          slot_no;

    colmix_top u_colmix_top (.clk(clk), .rst(rst), .pxl_cen(pxl_cen), .wb(wb),
        .wb_rsp(wb_rsp), .pxl(pxl), .rgb(rgb), .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // high every second clock, changes on the falling edge
    initial begin
        pxl_cen <= 1'b0;
        forever begin
            @(negedge clk);
            pxl_cen <= cen_on ? ~pxl_cen : 1'b0;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // prom address from the layer fields, then the bank/index of the winner
    function automatic logic [8:0] model_index(input pixel_in_t p, input layer_mask_t m);
        logic [7:0] a;
        a = {p.scr_pxl[7], p.obj_pxl[7], (p.obj_pxl[3:0] == 4'h0) || m.obj_off,
             (p.char_pxl[3:0] == 4'h0) || m.char_off, p.scr_pxl[3:0]};
        case (prom_sh[a])
            2'd2:    return {2'b01, p.obj_pxl[6:0]};
            2'd3:    return {2'b10, p.scr_pxl[6:0]};
            default: return {2'b00, p.char_pxl};   // codes 0 and 1
        endcase
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s rgb %h, expected %h", what, got, exp));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    task automatic check_blank(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s blank flags %b, expected %b", what, got, exp));
    endtask

    // one classic cycle, ack must come two clocks after the sampling edge
    task automatic wb_cycle(input logic we, input logic [10:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdat);
        int n;
        @(negedge clk);
        wb = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 10)
                stop_run("Wishbone ack never arrived");
        end while (!wb_rsp.ack);
        if (n != 3)
            report_mismatch($sformatf("ack %0d clocks after sampling, expected 2", n - 1));
        rdat = wb_rsp.dat;
        wb = '0;
    endtask

    task automatic wb_write(input logic [10:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read_check(input logic [10:0] adr, input logic [7:0] exp,
                                 input string what);
        logic [7:0] rd;
        wb_cycle(1'b0, adr, 8'h00, rd);
        check_byte(rd, exp, $sformatf("%s at %h", what, adr));
    endtask

    // one pixel per enable, output checked four slots later
    task automatic pixel_slot(input pixel_in_t p);
        exp_t       e;
        exp_t       old;
        logic [8:0] idx;
        int         n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 4)
                stop_run("pixel enable stopped toggling");
        end while (pxl_cen);   // low now, so the next rising edge is enabled
        if (exp_q.size() == 4) begin
            old = exp_q.pop_front();
            check_rgb(rgb, old.c, $sformatf("pixel %0d", slot_no - 4));
            check_blank({lhbl_dly, lvbl_dly}, old.fl, $sformatf("pixel %0d", slot_no - 4));
        end
        idx = model_index(p, cur_mask);
        e.fl = {~p.hbl, ~p.vbl};
        if (p.hbl || p.vbl)
            e.c = '0;
        else
            e.c = '{blue: b_sh[idx], green: gr_sh[idx][7:4], red: gr_sh[idx][3:0]};
        exp_q.push_back(e);
        pxl = p;
        slot_no++;
    endtask

    task automatic flush_pipe();
        repeat (4) pixel_slot(idle_px);
    endtask

    initial begin
        logic [7:0] rd;
        logic [8:0] idx;
        rst = 1'b1;
        cen_on = 1'b0;
        wb = '0;
        pxl = idle_px;
        lfsr = 32'hcf14_d8a9;
        cur_mask = '0;
        slot_no = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (wb_rsp.ack !== 1'b0)
            report_mismatch("ack high after reset");
        check_rgb(rgb, '0, "after reset");
        check_blank({lhbl_dly, lvbl_dly}, 2'b00, "after reset");
        @(posedge clk);
        cen_on = 1'b1;

        // random palette, blue writes carry junk in the upper nibble
        for (int i = 0; i < 512; i++) begin
            gr_sh[i] = rand_bits(8);
            wb_write(base_pal_gr + 11'(i), gr_sh[i]);
            rd = rand_bits(8);
            b_sh[i] = rd[3:0];
            wb_write(base_pal_b + 11'(i), rd);
        end
        for (int i = 0; i < 512; i++) begin
            wb_read_check(base_pal_gr + 11'(i), gr_sh[i], "red/green");
            wb_read_check(base_pal_b + 11'(i), {4'h0, b_sh[i]}, "blue");
        end

        wb_write(addr_ctrl, 8'hff);
        wb_read_check(addr_ctrl, 8'h03, "ctrl");   // only the two mask bits
        wb_write(addr_ctrl, 8'h00);
        wb_read_check(addr_ctrl, 8'h00, "ctrl");

        for (int a = 0; a < 256; a++) begin
            prom_sh[a] = prom_fill(8'(a));
            wb_write(base_prom + 11'(a), {6'd0, prom_sh[a]});
        end
        wb_read_check(base_prom + 11'h0a5, 8'h00, "prom");
        wb_read_check(base_prom + 11'h0ff, 8'h00, "prom");

        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].mask != cur_mask || rows[i].rw) begin
                flush_pipe();      // idle pixels cover the bus traffic
                if (rows[i].mask != cur_mask) begin
                    cur_mask = rows[i].mask;
                    wb_write(addr_ctrl, {6'd0, cur_mask.obj_off, cur_mask.char_off});
                end
                if (rows[i].rw) begin
                    idx = model_index(rows[i].px, cur_mask);
                    gr_sh[idx] = ~gr_sh[idx];   // always a new color
                    b_sh[idx] = ~b_sh[idx];
                    wb_write(base_pal_gr + {2'b00, idx}, gr_sh[idx]);
                    wb_write(base_pal_b + {2'b00, idx}, {4'h0, b_sh[idx]});
                end
            end
            pixel_slot(rows[i].px);
        end
        flush_pipe();

        $display("TB PASSED");
        $finish;
    end

endmodule

/* hw/colmix_top.sv */
// --------------------
// pixel path and cpu path share one clock
// pxl_cen is an enable, not a clock
// --------------------

`timescale 1ns/1ps

module colmix_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  colmix_pkg::wb_req_t   wb,
    output colmix_pkg::wb_rsp_t   wb_rsp,
    input  colmix_pkg::pixel_in_t pxl,
    output colmix_pkg::rgb_t      rgb,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly
);
    import colmix_pkg::*;

    // cpu side
    logic [7:0]        cpu_gr;
    logic [3:0]        cpu_b;
    logic [pal_aw-1:0] cpu_addr;
    mem_wr_t           gr_wr, b_wr;
    prom_wr_t          prom_wr;
    layer_mask_t       mask;

    // pixel side
    logic [prom_aw-1:0] prom_rd_addr;
    layer_e             prio;
    logic [pal_aw-1:0]  pal_rd_addr;
    logic [7:0]         pix_gr;
    logic [3:0]         pix_b;

    colmix_regs u_regs (.clk(clk), .rst(rst), .wb(wb), .wb_rsp(wb_rsp),
        .cpu_gr(cpu_gr), .cpu_b(cpu_b), .cpu_addr(cpu_addr),
        .gr_wr(gr_wr), .b_wr(b_wr), .prom_wr(prom_wr), .mask(mask));

    pal_ram u_pal (.clk(clk), .gr_wr(gr_wr), .b_wr(b_wr), .cpu_addr(cpu_addr),
        .cpu_gr(cpu_gr), .cpu_b(cpu_b), .pxl_cen(pxl_cen),
        .pal_rd_addr(pal_rd_addr), .pix_gr(pix_gr), .pix_b(pix_b));

    prio_prom u_prio (.clk(clk), .pxl_cen(pxl_cen), .prom_wr(prom_wr),
        .prom_rd_addr(prom_rd_addr), .prio(prio));

    colmix u_colmix (.clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pxl(pxl),
        .mask(mask), .prom_rd_addr(prom_rd_addr), .prio(prio),
        .pal_rd_addr(pal_rd_addr), .pix_gr(pix_gr), .pix_b(pix_b),
        .rgb(rgb), .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly));

endmodule

/* hw/colmix.sv */
// --------------------
// pixel in at pxl_cen edge k, color out after edge k+3
// layer mask only feeds the priority address
// --------------------

`timescale 1ns/1ps

module colmix (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pxl_cen,
    input  colmix_pkg::pixel_in_t          pxl,
    input  colmix_pkg::layer_mask_t        mask,
    output logic [colmix_pkg::prom_aw-1:0] prom_rd_addr,
    input  colmix_pkg::layer_e             prio,
    output logic [colmix_pkg::pal_aw-1:0]  pal_rd_addr,
    input  logic [7:0]                     pix_gr,
    input  logic [3:0]                     pix_b,
    output colmix_pkg::rgb_t               rgb,
    output logic                           lhbl_dly,
    output logic                           lvbl_dly
);
    import colmix_pkg::*;

    logic       obj_blank;
    logic       char_blank;
    logic [6:0] s1_char, s1_obj, s1_scr;  // wait for the prom
    logic [6:0] s2_char, s2_obj, s2_scr;  // lined up with prio
    // active-low {hbl, vbl}, index 0 holds the sampled pixel
    logic [blank_dly:0][1:0] lbl_sh;
    logic       px_blank;

    // transparent when the low nibble is zero, or hidden by the mask
    assign obj_blank  = ~|pxl.obj_pxl[3:0] | mask.obj_off;
    assign char_blank = ~|pxl.char_pxl[3:0] | mask.char_off;

    // stage 1 prom address and pixel fields
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            prom_rd_addr <= {pxl.scr_pxl[7], pxl.obj_pxl[7], obj_blank, char_blank,
                             pxl.scr_pxl[3:0]};
            s1_char <= pxl.char_pxl;
            s1_obj  <= pxl.obj_pxl[6:0];
            s1_scr  <= pxl.scr_pxl[6:0];
        end
    end

    // stage 2, fields move along as the prom answers
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            s2_char <= s1_char;
            s2_obj  <= s1_obj;
            s2_scr  <= s1_scr;
        end
    end

    // palette index, bank in the top two bits
    always_comb begin
        case (prio)
            layer_obj: pal_rd_addr = {2'b01, s2_obj};
            layer_scr: pal_rd_addr = {2'b10, s2_scr};
            default:   pal_rd_addr = {2'b00, s2_char};
        endcase
    end

    // blank flags, reset to blanked
    always_ff @(posedge clk) begin
        if (rst)
            lbl_sh <= '0;
        else if (pxl_cen)
            lbl_sh <= {lbl_sh[blank_dly-1:0], ~{pxl.hbl, pxl.vbl}};
    end

    assign px_blank = ~&lbl_sh[blank_dly-1];   // either flag low

    // stage 3 color out
    always_ff @(posedge clk) begin
        if (rst)
            rgb <= '0;
        else if (pxl_cen)
            rgb <= px_blank ? '0 : {pix_b, pix_gr};  // gr is {green, red}
    end

    assign {lhbl_dly, lvbl_dly} = lbl_sh[blank_dly];

    // only three banks hold colors
    a_no_bank3: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |-> pal_rd_addr[pal_aw-1 -: 2] != 2'b11);

endmodule

/* hw/colmix_regs.sv */
// --------------------
// ack two clocks after cyc and stb are first sampled
// master must drop stb after the single ack clock
// prom reads back as zero
// ctrl bit 0 is char_off and bit 1 obj_off
// --------------------

`timescale 1ns/1ps

module colmix_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  colmix_pkg::wb_req_t           wb,
    output colmix_pkg::wb_rsp_t           wb_rsp,
    input  logic [7:0]                    cpu_gr,
    input  logic [3:0]                    cpu_b,
    output logic [colmix_pkg::pal_aw-1:0] cpu_addr,
    output colmix_pkg::mem_wr_t           gr_wr,
    output colmix_pkg::mem_wr_t           b_wr,
    output colmix_pkg::prom_wr_t          prom_wr,
    output colmix_pkg::layer_mask_t       mask
);
    import colmix_pkg::*;

    logic [1:0]       cnt;      // 0 idle, 1 and 2 waiting
    logic [wb_aw-1:0] lat_adr;
    logic [7:0]       lat_dat;
    logic             lat_we;
    logic             ack_r;
    logic [7:0]       dat_r;
    logic [7:0]       rd_mux;
    logic             start;
    logic             wr_now;
    logic             ctrl_we;
    logic             sel_gr, sel_b, sel_prom, sel_ctrl;

    // new cycle only when idle, and not on the ack clock itself
    assign start = wb.cyc && wb.stb && !ack_r && (cnt == 2'd0);

    // decode on the latched address
    assign sel_gr   = lat_adr[wb_aw-1:pal_aw] == base_pal_gr[wb_aw-1:pal_aw];
    assign sel_b    = lat_adr[wb_aw-1:pal_aw] == base_pal_b[wb_aw-1:pal_aw];
    assign sel_prom = lat_adr[wb_aw-1:prom_aw] == base_prom[wb_aw-1:prom_aw];
    assign sel_ctrl = lat_adr == addr_ctrl;

    assign wr_now  = (cnt == 2'd2) && lat_we && wb.cyc; // same edge as ack
    assign ctrl_we = wr_now && sel_ctrl;

    assign cpu_addr = lat_adr[pal_aw-1:0];  // ram read starts one clock early
    assign gr_wr    = '{addr: lat_adr[pal_aw-1:0], data: lat_dat, we: wr_now && sel_gr};
    assign b_wr     = '{addr: lat_adr[pal_aw-1:0], data: lat_dat, we: wr_now && sel_b};
    assign prom_wr  = '{addr: lat_adr[prom_aw-1:0], data: lat_dat[1:0],
                        we: wr_now && sel_prom};

    always_comb begin
        if (sel_gr)
            rd_mux = cpu_gr;
        else if (sel_b)
            rd_mux = {4'h0, cpu_b};  // upper nibble reads zero
        else if (sel_ctrl)
            rd_mux = {6'd0, mask.obj_off, mask.char_off};
        else
            rd_mux = 8'h00;          // prom and holes
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= 2'd0;
            ack_r <= 1'b0;
            mask  <= '0;
        end else begin
            ack_r <= 1'b0;
            if (!wb.cyc) begin
                cnt <= 2'd0;         // master gave up
            end else begin
                case (cnt)
                    2'd0: if (start) cnt <= 2'd1;
                    2'd1: cnt <= 2'd2;
                    default: begin
                        cnt   <= 2'd0;
                        ack_r <= 1'b1;
                    end
                endcase
            end
            if (ctrl_we) begin
                mask.char_off <= lat_dat[0];
                mask.obj_off  <= lat_dat[1];
            end
        end
    end

    // request payload latched when a cycle starts
    always_ff @(posedge clk) begin
        if (start) begin
            lat_adr <= wb.adr;
            lat_dat <= wb.dat;
            lat_we  <= wb.we;
        end
        if (cnt == 2'd2)
            dat_r <= rd_mux;         // ram data settled a clock ago
    end

    assign wb_rsp = '{ack: ack_r, dat: dat_r};

    // master sees a single clock of ack per cycle
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack);

    a_one_we: assert property (@(posedge clk) disable iff (rst)
        $onehot0({gr_wr.we, b_wr.we, prom_wr.we, ctrl_we}));

endmodule

/* hw/prio_prom.sv */
// --------------------
// contents come from cpu writes only
// lookup registered on pxl_cen
// --------------------

`timescale 1ns/1ps

module prio_prom (
    input  logic                           clk,
    input  logic                           pxl_cen,
    input  colmix_pkg::prom_wr_t           prom_wr,
    input  logic [colmix_pkg::prom_aw-1:0] prom_rd_addr,
    output colmix_pkg::layer_e             prio
);
    import colmix_pkg::*;

    logic [1:0] mem [2 ** prom_aw];
    logic [1:0] code;

    always_ff @(posedge clk) begin
        if (prom_wr.we)
            mem[prom_wr.addr] <= prom_wr.data;
    end

    assign code = mem[prom_rd_addr];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            case (code)
                2'd2:    prio <= layer_obj;
                2'd3:    prio <= layer_scr;
                default: prio <= layer_char;  // codes 0 and 1
            endcase
        end
    end

    // bus side must hand over a clean address
    a_wr_addr_known: assert property (@(posedge clk)
        prom_wr.we |-> !$isunknown(prom_wr.addr));

endmodule

/* hw/pal_ram.sv */
// --------------------
// true dual port whose contents are not reset
// pixel port reads old data on a same-clock write
// --------------------

`timescale 1ns/1ps

module pal_ram (
    input  logic                          clk,
    input  colmix_pkg::mem_wr_t           gr_wr,
    input  colmix_pkg::mem_wr_t           b_wr,
    input  logic [colmix_pkg::pal_aw-1:0] cpu_addr,
    output logic [7:0]                    cpu_gr,
    output logic [3:0]                    cpu_b,
    input  logic                          pxl_cen,
    input  logic [colmix_pkg::pal_aw-1:0] pal_rd_addr,
    output logic [7:0]                    pix_gr,
    output logic [3:0]                    pix_b
);
    import colmix_pkg::*;

    logic [7:0] gr_mem [2 ** pal_aw];   // green in the high nibble over red
    logic [3:0] b_mem  [2 ** pal_aw];

    // red/green bank
    always_ff @(posedge clk) begin
        if (gr_wr.we)
            gr_mem[gr_wr.addr] <= gr_wr.data;
        cpu_gr <= gr_mem[cpu_addr];   // every clock
    end

    always_ff @(posedge clk) begin
        if (pxl_cen)
            pix_gr <= gr_mem[pal_rd_addr];
    end

    // blue bank
    always_ff @(posedge clk) begin
        if (b_wr.we)
            b_mem[b_wr.addr] <= b_wr.data[3:0]; // upper bits dropped
        cpu_b <= b_mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        if (pxl_cen)
            pix_b <= b_mem[pal_rd_addr];
    end

endmodule

/* hw/colmix_pkg.sv */
// --------------------
// sizes are fixed by the board
// address map is byte based on an 8-bit Wishbone bus
// --------------------

package colmix_pkg;

    localparam int pal_aw  = 9;  // 512 palette entries
    localparam int prom_aw = 8;  // 256 priority codes
    localparam int wb_aw   = 11;

    // cpu address map
    localparam logic [wb_aw-1:0] base_pal_gr = 11'h000; // red/green bank
    localparam logic [wb_aw-1:0] base_pal_b  = 11'h200; // blue bank
    localparam logic [wb_aw-1:0] base_prom   = 11'h400; // write only
    localparam logic [wb_aw-1:0] addr_ctrl   = 11'h500;

    // pixel enables from the input sample to the output register
    localparam int blank_dly = 3;

    // prom code 1 also means char
    typedef enum logic [1:0] {
        layer_char = 2'd0,
        layer_obj  = 2'd2,
        layer_scr  = 2'd3
    } layer_e;

    typedef struct packed {
        logic [6:0] char_pxl;
        logic [7:0] obj_pxl;
        logic [7:0] scr_pxl;
        logic       hbl;      // active high
        logic       vbl;
    } pixel_in_t;

    typedef struct packed {
        logic [3:0] blue;
        logic [3:0] green;
        logic [3:0] red;
    } rgb_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [wb_aw-1:0] adr;
        logic [7:0]       dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [pal_aw-1:0] addr;
        logic [7:0]        data;  // blue bank keeps the low nibble
        logic              we;
    } mem_wr_t;

    typedef struct packed {
        logic [prom_aw-1:0] addr;
        logic [1:0]         data;
        logic               we;
    } prom_wr_t;

    typedef struct packed {
        logic char_off;
        logic obj_off;
    } layer_mask_t;

endpackage
